// ==== mac_kbd_macros.svh ====
`ifndef MAC_KBD_MACROS_SVH
`define MAC_KBD_MACROS_SVH

// Pace timer
`define MAC_KBD_PACE_W 14
`define MAC_KBD_TICK_SHORT 14'd4095
`define MAC_KBD_TICK_LONG {`MAC_KBD_PACE_W{1'b1}}

// Reply bytes
`define MAC_KBD_NULL_CODE 8'h7b
`define MAC_KBD_KEYPAD_PREFIX 8'h79
`define MAC_KBD_MODEL_REPLY 8'h03
`define MAC_KBD_TEST_REPLY 8'h7d

`define MAC_KBD_CAPS_SCANCODE 8'h58

`endif

// ==== mac_kbd_pkg.sv ====
`default_nettype none

package mac_kbd_pkg;

	// Host command bytes
	typedef enum logic [7:0] {
		CMD_NONE    = 8'h00,
		CMD_INQUIRY = 8'h10,
		CMD_INSTANT = 8'h14,
		CMD_MODEL   = 8'h16,
		CMD_TEST    = 8'h36
	} mac_cmd_e;

	typedef struct packed {
		logic       extended;
		logic [7:0] scancode;
	} ps2_addr_t;

	typedef struct packed {
		logic       keypad; // Needs the prefix byte
		logic       unused; // Release flag slot once queued
		logic [6:0] key;
	} mac_code_t;

endpackage

`default_nettype wire

// ==== key_event_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// A pop with prefix high clears prefix only, otherwise it clears pending.
// A pop while pending is low is a null reply and leaves the queue alone.
// After a model or test reply the responder pops once per owed byte,
// so a queued keypad key is flushed over two back-to-back cycles.
interface key_event_if;
	logic       pending;
	logic       prefix;
	logic [7:0] mac_byte; // Release flag in bit 7
	logic       pop;

	modport capture (output pending, output prefix, output mac_byte, input pop);
	modport responder (input pending, input prefix, input mac_byte, output pop);
endinterface

`default_nettype wire

// ==== scancode_map.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mac_kbd_macros.svh"

module scancode_map import mac_kbd_pkg::*; (
	input  wire            clk,
	input  wire ps2_addr_t ps2_key_addr,
	output mac_code_t      mac_code
);

	ps2_addr_t  addr_q;
	logic [8:0] entry;

	always_ff @(posedge clk) begin
		addr_q <= ps2_key_addr;
	end

	always_comb begin
		case (addr_q)
			9'h01c: entry = 9'h001; // a
			9'h032: entry = 9'h017;
			9'h021: entry = 9'h011;
			9'h023: entry = 9'h005;
			9'h024: entry = 9'h01d;
			9'h02b: entry = 9'h007;
			9'h034: entry = 9'h00b;
			9'h033: entry = 9'h009;
			9'h043: entry = 9'h045;
			9'h03b: entry = 9'h04d;
			9'h042: entry = 9'h051;
			9'h04b: entry = 9'h04b;
			9'h03a: entry = 9'h05d;
			9'h031: entry = 9'h05b;
			9'h044: entry = 9'h03f;
			9'h04d: entry = 9'h047;
			9'h015: entry = 9'h019;
			9'h02d: entry = 9'h01f;
			9'h01b: entry = 9'h003;
			9'h02c: entry = 9'h023;
			9'h03c: entry = 9'h041;
			9'h02a: entry = 9'h013;
			9'h01d: entry = 9'h01b;
			9'h022: entry = 9'h00f;
			9'h035: entry = 9'h021;
			9'h01a: entry = 9'h00d; // z
			9'h045: entry = 9'h03b; // 0
			9'h016: entry = 9'h025;
			9'h01e: entry = 9'h027;
			9'h026: entry = 9'h029;
			9'h025: entry = 9'h02b;
			9'h02e: entry = 9'h02f;
			9'h036: entry = 9'h02d;
			9'h03d: entry = 9'h035;
			9'h03e: entry = 9'h039;
			9'h046: entry = 9'h033; // 9
			9'h029: entry = 9'h063; // Space
			9'h05a: entry = 9'h049; // Enter
			9'h066: entry = 9'h067; // Backspace
			9'h00d: entry = 9'h061; // Tab
			9'h012: entry = 9'h071; // Left shift
			9'h059: entry = 9'h071; // Right shift
			9'h011: entry = 9'h06f; // Left alt as command
			9'h111: entry = 9'h06f; // Right alt as command
			9'h058: entry = 9'h073; // Capslock
			9'h070: entry = 9'h125; // KP 0
			9'h069: entry = 9'h127; // KP 1
			9'h072: entry = 9'h129;
			9'h07a: entry = 9'h12b;
			9'h06b: entry = 9'h12d;
			9'h073: entry = 9'h12f;
			9'h074: entry = 9'h131;
			9'h06c: entry = 9'h133;
			9'h075: entry = 9'h137;
			9'h07d: entry = 9'h139; // KP 9
			9'h071: entry = 9'h103; // KP .
			9'h079: entry = 9'h10d; // KP +
			9'h07b: entry = 9'h11d; // KP -
			9'h07c: entry = 9'h105; // KP *
			9'h14a: entry = 9'h11b; // KP /
			9'h15a: entry = 9'h119; // KP enter
			9'h16b: entry = 9'h10d; // Arrow left
			9'h174: entry = 9'h105; // Arrow right
			9'h175: entry = 9'h11b; // Arrow up
			9'h172: entry = 9'h111; // Arrow down
			default: entry = {1'b0, `MAC_KBD_NULL_CODE};
		endcase
	end

	assign mac_code = entry;

endmodule

`default_nettype wire

// ==== key_capture.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mac_kbd_macros.svh"

module key_capture import mac_kbd_pkg::*; (
	input  wire            clk,
	input  wire            reset,
	input  wire     [10:0] ps2_key,
	input  wire mac_code_t mac_code,
	output ps2_addr_t      ps2_key_addr,
	output logic           capslock,
	key_event_if.capture   key
);

	logic stb_q;
	logic toggle_q;
	logic pressed;
	logic extended;
	logic is_caps;

	assign pressed  = ps2_key[9];
	assign extended = ps2_key[8];
	assign is_caps  = !extended && ps2_key[7:0] == `MAC_KBD_CAPS_SCANCODE;

	assign ps2_key_addr = {extended, ps2_key[7:0]};

	// Toggle shows up once the table output matches the new address
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			stb_q    <= 1'b0;
			toggle_q <= 1'b0;
		end else begin
			stb_q    <= ps2_key[10];
			toggle_q <= ps2_key[10] != stb_q;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			capslock <= 1'b0;
		end else if (toggle_q && is_caps && pressed) begin
			capslock <= ~capslock;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			key.pending <= 1'b0;
			key.prefix  <= 1'b0;
		end else if (key.pop && key.pending) begin
			if (key.prefix) begin
				key.prefix <= 1'b0; // Prefix sent, code still owed
			end else begin
				key.pending <= 1'b0;
			end
		end else if (toggle_q && !key.pending && !(is_caps && capslock)) begin
			key.pending <= 1'b1;
			key.prefix  <= mac_code.keypad;
		end
	end

	always_ff @(posedge clk) begin
		if (toggle_q && !key.pending) begin
			key.mac_byte <= {~pressed, mac_code.key};
		end
	end

endmodule

`default_nettype wire

// ==== host_responder.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mac_kbd_macros.svh"

module host_responder import mac_kbd_pkg::*; (
	input  wire            clk,
	input  wire            reset,
	input  wire      [7:0] data_out,
	input  wire            strobe_out,
	output logic     [7:0] data_in,
	output logic           strobe_in,
	key_event_if.responder key
);

	mac_cmd_e                   cmd;
	logic [`MAC_KBD_PACE_W-1:0] pace;
	logic                       tick_short;
	logic                       tick_long;
	logic                       inquiry_active;
	logic                       fixed_reply;
	logic                       key_reply;
	logic                       flush_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cmd <= CMD_NONE;
		end else if (strobe_out) begin
			case (data_out)
				CMD_INQUIRY: cmd <= CMD_INQUIRY;
				CMD_INSTANT: cmd <= CMD_INSTANT;
				CMD_MODEL:   cmd <= CMD_MODEL;
				CMD_TEST:    cmd <= CMD_TEST;
				default:     cmd <= CMD_NONE;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pace <= '0;
		end else if (strobe_out) begin
			pace <= `MAC_KBD_PACE_W'(1); // Strobe cycle counts as the first
		end else if (!tick_long) begin
			pace <= pace + 1'b1;
		end
	end

	assign tick_short = pace == `MAC_KBD_TICK_SHORT;
	assign tick_long  = pace == `MAC_KBD_TICK_LONG;

	// Inquiry waits for a key between the two ticks
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			inquiry_active <= 1'b0;
		end else if (strobe_out || strobe_in) begin
			inquiry_active <= 1'b0;
		end else if (tick_short) begin
			inquiry_active <= cmd == CMD_INQUIRY;
		end
	end

	assign fixed_reply = (cmd == CMD_MODEL || cmd == CMD_TEST) && tick_short;
	assign key_reply   = (cmd == CMD_INSTANT && tick_short) ||
		(inquiry_active && (key.pending || tick_long));
	assign strobe_in   = fixed_reply || key_reply;

	// Second pop for a keypad key caught by the flush
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			flush_q <= 1'b0;
		end else begin
			flush_q <= fixed_reply && key.pending && key.prefix;
		end
	end

	assign key.pop = strobe_in || (flush_q && key.pending);

	always_comb begin
		if (cmd == CMD_TEST) begin
			data_in = `MAC_KBD_TEST_REPLY;
		end else if (cmd == CMD_MODEL) begin
			data_in = `MAC_KBD_MODEL_REPLY;
		end else if (key.pending) begin
			data_in = key.prefix ? `MAC_KBD_KEYPAD_PREFIX : key.mac_byte;
		end else begin
			data_in = `MAC_KBD_NULL_CODE;
		end
	end

endmodule

`default_nettype wire

// ==== mac_kbd.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_kbd import mac_kbd_pkg::*; (
	input  wire        clk,
	input  wire        reset,

	input  wire [10:0] ps2_key,
	output wire        capslock,

	input  wire  [7:0] data_out,
	input  wire        strobe_out,
	output wire  [7:0] data_in,
	output wire        strobe_in
);

	ps2_addr_t key_addr;
	mac_code_t mac_code;

	key_event_if key_if ();

	scancode_map scancode_map_inst (
		.clk          (clk),
		.ps2_key_addr (key_addr),
		.mac_code     (mac_code)
	);

	key_capture key_capture_inst (
		.clk          (clk),
		.reset        (reset),
		.ps2_key      (ps2_key),
		.mac_code     (mac_code),
		.ps2_key_addr (key_addr),
		.capslock     (capslock),
		.key          (key_if.capture)
	);

	host_responder host_responder_inst (
		.clk        (clk),
		.reset      (reset),
		.data_out   (data_out),
		.strobe_out (strobe_out),
		.data_in    (data_in),
		.strobe_in  (strobe_in),
		.key        (key_if.responder)
	);

endmodule

`default_nettype wire

// ==== mac_kbd_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module mac_kbd_properties (
	input wire        clk,
	input wire        reset,
	input wire [10:0] ps2_key,
	input wire        capslock,
	input wire  [7:0] data_in,
	input wire        strobe_in
);

	int fail_count = 0;

	strobe_single: assert property (@(posedge clk) disable iff (reset)
		strobe_in |=> !strobe_in)
		else begin
			fail_count++;
			$error("strobe_in high for two cycles in a row");
		end

	data_known: assert property (@(posedge clk) disable iff (reset)
		strobe_in |-> !$isunknown(data_in))
		else begin
			fail_count++;
			$error("data_in unknown while strobe_in is high");
		end

	// Flip lands two edges after the toggle is sampled
	caps_after_toggle: assert property (@(posedge clk) disable iff (reset)
		$changed(capslock) |->
			($past(ps2_key[10], 1) != $past(ps2_key[10], 2)) ||
			($past(ps2_key[10], 2) != $past(ps2_key[10], 3)))
		else begin
			fail_count++;
			$error("capslock changed with no recent ps2_key toggle");
		end

endmodule

bind mac_kbd mac_kbd_properties mac_kbd_properties_inst (
	.clk       (clk),
	.reset     (reset),
	.ps2_key   (ps2_key),
	.capslock  (capslock),
	.data_in   (data_in),
	.strobe_in (strobe_in)
);

`default_nettype wire

// ==== tb_mac_kbd.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mac_kbd_macros.svh"

module tb_mac_kbd;

	localparam int         MAX_LINES  = 128;
	localparam int         TICK_SHORT = int'(`MAC_KBD_TICK_SHORT);
	localparam int         TICK_LONG  = int'(`MAC_KBD_TICK_LONG);
	localparam logic [7:0] NULL_CODE  = `MAC_KBD_NULL_CODE;
	localparam logic [7:0] INQUIRY    = 8'h10;

	logic        clk;
	logic        reset;
	logic [10:0] ps2_key;
	logic        capslock;
	logic  [7:0] data_out;
	logic        strobe_out;
	logic  [7:0] data_in;
	logic        strobe_in;

	logic [11:0] vec_mem [0:3*MAX_LINES-1]; // Kind, operand, expected per line
	int          n_lines;
	logic        loaded;
	int          cycle_count = 0;
	int          send_cycle;
	int          press_cycle;
	logic  [7:0] reply_data [$];
	int          reply_stamp [$];

	mac_kbd mac_kbd_inst (
		.clk        (clk),
		.reset      (reset),
		.ps2_key    (ps2_key),
		.capslock   (capslock),
		.data_out   (data_out),
		.strobe_out (strobe_out),
		.data_in    (data_in),
		.strobe_in  (strobe_in)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Reply pulses collected mid-cycle
	always @(negedge clk) begin
		if (strobe_in) begin
			reply_data.push_back(data_in);
			reply_stamp.push_back(cycle_count);
		end
	end

	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// New PS/2 event, held for two edges
	task automatic drive_key(input logic [9:0] event_bits);
		ps2_key     = {~ps2_key[10], event_bits};
		press_cycle = cycle_count;
		repeat (3) @(negedge clk);
	endtask

	task automatic send_command(input logic [7:0] cmd);
		@(posedge clk);
		assert (reply_data.size() == 0) else begin
			$display("Reply 0x%0h arrived with no command waiting at %0t", reply_data[0], $time);
			stop_run();
		end
		@(negedge clk);
		data_out   = cmd;
		strobe_out = 1'b1;
		send_cycle = cycle_count;
		@(negedge clk);
		strobe_out = 1'b0;
	endtask

	task automatic wait_reply(input int limit, output logic [7:0] data, output int stamp);
		int waited;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
			assert (waited <= limit) else begin
				$display("No reply on strobe_in within %0d cycles at %0t", limit, $time);
				stop_run();
			end
		end while (reply_data.size() == 0);
		data  = reply_data.pop_front();
		stamp = reply_stamp.pop_front();
		@(negedge clk);
	endtask

	function automatic int expected_latency(input logic [7:0] cmd, input logic [7:0] reply);
		if (cmd != INQUIRY) begin
			return TICK_SHORT;
		end else if (reply == NULL_CODE) begin
			return TICK_LONG;
		end
		return TICK_SHORT + 1; // Key queued before the inquiry
	endfunction

	initial begin
		logic  [3:0] kind;
		logic [11:0] operand;
		logic  [7:0] expected;
		logic  [7:0] reply;
		int          stamp;

		reset      = 1'b1;
		ps2_key    = '0;
		data_out   = '0;
		strobe_out = 1'b0;
		loaded     = 1'b0;
		n_lines    = 0;
		$readmemh("mac_kbd_vectors.txt", vec_mem);
		while (n_lines < MAX_LINES && vec_mem[3*n_lines][3:0] != 4'h0) begin
			n_lines++;
		end
		assert (n_lines > 0) else begin
			$display("No vectors read from mac_kbd_vectors.txt");
			stop_run();
		end
		loaded = 1'b1;

		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int line = 0; line < n_lines; line++) begin
			kind     = vec_mem[3*line][3:0];
			operand  = vec_mem[3*line+1];
			expected = vec_mem[3*line+2][7:0];
			case (kind)
				4'h1: drive_key(operand[9:0]);
				4'h2: begin
					send_command(operand[7:0]);
					wait_reply(TICK_LONG + 16, reply, stamp);
					check_value("data_in", 32'(reply), 32'(expected));
					check_value("reply latency", stamp - send_cycle,
						expected_latency(operand[7:0], expected));
				end
				4'h3: check_value("capslock", 32'(capslock), 32'(expected[0]));
				4'h4: send_command(operand[7:0]); // Reply picked up later
				4'h5: begin
					wait_reply(TICK_LONG + 16, reply, stamp);
					check_value("data_in", 32'(reply), 32'(expected));
					assert (stamp - press_cycle <= int'(operand)) else begin
						$display("Reply came %0d cycles after the key event, limit %0d",
							stamp - press_cycle, operand);
						stop_run();
					end
				end
				4'h6: repeat (int'(operand)) @(negedge clk);
				default: begin
					$display("Unknown vector kind %0h on line %0d", kind, line);
					stop_run();
				end
			endcase
		end

		@(posedge clk);
		assert (reply_data.size() == 0) else begin
			$display("Extra reply 0x%0h after the last vector", reply_data[0]);
			stop_run();
		end
		if (mac_kbd_inst.mac_kbd_properties_inst.fail_count == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			$display("%0d bound assertion failures during the run",
				mac_kbd_inst.mac_kbd_properties_inst.fail_count);
			stop_run();
		end
	end

	// Watchdog sized for the worst case of every line
	initial begin
		int limit;
		wait (loaded);
		limit = 8 + n_lines * (TICK_LONG + 100);
		repeat (limit) @(posedge clk);
		$display("Timeout: run did not finish within %0d cycles", limit);
		stop_run();
	end

endmodule

`default_nettype wire

// ==== mac_kbd_vectors.txt ====
// Columns: kind operand expected, all hex
// Kinds: 1 key {pressed, extended, scancode}, 2 command and reply, 3 capslock,
// 4 command only, 5 reply within operand cycles of the last key, 6 idle, 0 end
// Model and test
2 016 03
2 036 7d
// Instant with key a
2 014 7b
1 21c 00
2 014 01
1 01c 00
2 014 81
// Keypad 1 sends the prefix first
1 269 00
2 014 79
2 014 27
1 069 00
2 014 79
2 014 a7
// Arrow left is extended
1 36b 00
2 014 79
2 014 0d
// Inquiry with b queued, then empty, then c during the wait
1 232 00
2 010 17
1 032 00
2 014 97
2 010 7b
4 010 00
6 fff 00
6 100 00
1 221 00
5 004 11
1 021 00
2 014 91
// Capslock
1 258 00
2 014 73
3 000 01
1 058 00
2 014 7b
1 258 00
2 014 7b
3 000 00
1 058 00
2 014 f3
// Model and test replies flush the queue
1 224 00
2 016 03
2 014 7b
1 272 00
2 036 7d
2 014 7b
// Second key lost
1 223 00
1 22b 00
2 014 05
2 014 7b
0 000 00

// ==== files.f ====
+incdir+.
mac_kbd_pkg.sv
key_event_if.sv
scancode_map.sv
key_capture.sv
host_responder.sv
mac_kbd.sv
mac_kbd_properties.sv
tb_mac_kbd.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run tb_mac_kbd with Verilator and check the log for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mac_kbd -f files.f > sim.log 2>&1 &&
	./obj_dir/Vtb_mac_kbd >> sim.log 2>&1

grep -qx "NO ERRORS" sim.log && echo "Simulation passed" ||
	{ tail -n 20 sim.log; echo "Simulation failed, see sim.log"; exit 1; }
